//--- verilog/fitnessPkg.sv
package fitnessPkg;

    localparam int DataWidth    = 8;    // Profile inputs, seconds, speed, heart rate
    localparam int CalorieWidth = 24;   // Weight x rate x seconds
    localparam int SecondsWrap  = 59;   // Last count before rolling over to 0

    // Calories per unit of weight per second
    localparam int RateRun   = 10;
    localparam int RateWalk  = 5;
    localparam int RateCycle = 8;

    localparam int FifoDepth = 4;                    // Power of two, pointers wrap naturally
    localparam int PtrWidth  = $clog2(FifoDepth);
    localparam int StepWidth = $clog2(DataWidth);    // Divider step counter

    typedef enum logic [1:0] {
        actIdle  = 2'd0,
        actRun   = 2'd1,
        actWalk  = 2'd2,
        actCycle = 2'd3
    } activityT;

    typedef enum logic [1:0] {
        idle    = 2'd0,    // Waiting for a sample
        calc    = 2'd1,    // Latch seconds, calories and time total
        divide  = 2'd2,    // Serial divide for speed
        publish = 2'd3     // Drive outputs and resultValid
    } engineStateT;

endpackage

//--- verilog/activityTimer.sv
`timescale 1ns/1ps

module activityTimer import fitnessPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 secTick,        // One-second strobe
    input  activityT             activity,
    input  logic                 sampleReady,
    output logic                 sampleValid,
    output activityT             sampleActivity,
    output logic [DataWidth-1:0] sampleSeconds
);

    logic [DataWidth-1:0] secRun;
    logic [DataWidth-1:0] secWalk;
    logic [DataWidth-1:0] secCycle;
    logic [DataWidth-1:0] curSeconds;
    logic [DataWidth-1:0] nextSeconds;
    logic                 tickActive;

    assign tickActive = secTick && (activity != actIdle);    // Idle ticks are dropped

    always_comb begin
        case (activity)
            actRun:   curSeconds = secRun;
            actWalk:  curSeconds = secWalk;
            actCycle: curSeconds = secCycle;
            default:  curSeconds = '0;
        endcase
    end

    assign nextSeconds = (curSeconds == DataWidth'(SecondsWrap)) ? '0
                                                                  : curSeconds + DataWidth'(1);

    // Only the running activity advances
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            secRun   <= '0;
            secWalk  <= '0;
            secCycle <= '0;
        end else if (tickActive) begin
            case (activity)
                actRun:   secRun   <= nextSeconds;
                actWalk:  secWalk  <= nextSeconds;
                actCycle: secCycle <= nextSeconds;
                default:  ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sampleValid    <= 1'b0;
            sampleActivity <= actIdle;
            sampleSeconds  <= '0;
        end else if (tickActive) begin
            sampleValid    <= 1'b1;           // Offer the updated count
            sampleActivity <= activity;
            sampleSeconds  <= nextSeconds;
        end else if (sampleReady) begin
            sampleValid <= 1'b0;              // Taken by the FIFO
        end
    end

    // A tick may not overwrite a sample the FIFO has not accepted yet
    tickWhilePending: assert property (@(posedge clk) disable iff (rst)
        tickActive |-> (!sampleValid || sampleReady))
        else $error("activityTimer: tick while previous sample still pending");

endmodule

//--- verilog/sampleFifo.sv
`timescale 1ns/1ps

module sampleFifo import fitnessPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sampleValid,
    input  activityT             sampleActivity,
    input  logic [DataWidth-1:0] sampleSeconds,
    output logic                 sampleReady,
    output logic                 fifoValid,
    output activityT             fifoActivity,
    output logic [DataWidth-1:0] fifoSeconds,
    input  logic                 fifoReady
);

    activityT             memActivity [FifoDepth];
    logic [DataWidth-1:0] memSeconds  [FifoDepth];
    logic [PtrWidth-1:0]  wrPtr;
    logic [PtrWidth-1:0]  rdPtr;
    logic [PtrWidth:0]    count;          // One extra bit to tell full from empty
    logic                 doWrite;
    logic                 doRead;

    assign sampleReady = (count != FifoDepth);
    assign fifoValid   = (count != '0);
    assign doWrite     = sampleValid && sampleReady;
    assign doRead      = fifoValid && fifoReady;

    assign fifoActivity = memActivity[rdPtr];    // Head of the queue
    assign fifoSeconds  = memSeconds[rdPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            memActivity[wrPtr] <= sampleActivity;
            memSeconds[wrPtr]  <= sampleSeconds;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + PtrWidth'(1);
            end
            if (doRead) begin
                rdPtr <= rdPtr + PtrWidth'(1);
            end
            case ({doWrite, doRead})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                     // Both or neither leave the level alone
            endcase
        end
    end

    // A sample refused while full has to wait unchanged, or it would be lost
    heldWhileFull: assert property (@(posedge clk) disable iff (rst)
        sampleValid && !sampleReady |=> sampleValid && $stable(sampleActivity)
                                        && $stable(sampleSeconds))
        else $error("sampleFifo: sample dropped or changed while full");

    // Pointer distance has to track the occupancy
    ptrMatchesCount: assert property (@(posedge clk) disable iff (rst)
        PtrWidth'(wrPtr - rdPtr) == count[PtrWidth-1:0])
        else $error("sampleFifo: pointers disagree with count");

endmodule

//--- verilog/serialDivider.sv
`timescale 1ns/1ps

module serialDivider import fitnessPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 divStart,
    input  logic [DataWidth-1:0] dividend,
    input  logic [DataWidth-1:0] divisor,
    output logic                 divDone,
    output logic [DataWidth-1:0] quotient
);

    logic [DataWidth-1:0] remReg;
    logic [DataWidth-1:0] quoReg;
    logic [DataWidth-1:0] divisorReg;
    logic [StepWidth-1:0] stepsLeft;
    logic                 busy;
    logic [DataWidth-1:0] remIn;
    logic [DataWidth-1:0] quoIn;
    logic [DataWidth-1:0] divIn;
    logic [DataWidth:0]   trial;
    logic [DataWidth:0]   diff;
    logic [DataWidth-1:0] remNext;
    logic [DataWidth-1:0] quoNext;

    // First step runs on the fresh operands in the start cycle
    assign remIn = divStart ? '0 : remReg;
    assign quoIn = divStart ? dividend : quoReg;
    assign divIn = divStart ? divisor : divisorReg;

    assign trial = {remIn, quoIn[DataWidth-1]};    // Shift in next dividend bit
    assign diff  = trial - {1'b0, divIn};

    always_comb begin
        if (diff[DataWidth]) begin                   // Negative, keep the shifted remainder
            remNext = trial[DataWidth-1:0];
            quoNext = {quoIn[DataWidth-2:0], 1'b0};
        end else begin
            remNext = diff[DataWidth-1:0];
            quoNext = {quoIn[DataWidth-2:0], 1'b1};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            remReg     <= '0;
            quoReg     <= '0;
            divisorReg <= '0;
            stepsLeft  <= '0;
            busy       <= 1'b0;
            divDone    <= 1'b0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                remReg     <= remNext;
                quoReg     <= quoNext;
                divisorReg <= divisor;
                stepsLeft  <= StepWidth'(DataWidth - 1);
                busy       <= 1'b1;
            end else if (busy) begin
                remReg    <= remNext;
                quoReg    <= quoNext;
                stepsLeft <= stepsLeft - 1'b1;
                if (stepsLeft == StepWidth'(1)) begin
                    busy    <= 1'b0;              // Last quotient bit lands now
                    divDone <= 1'b1;
                end
            end
        end
    end

    assign quotient = quoReg;

    // The engine must wait for divDone and must skip a zero time total
    startLegal: assert property (@(posedge clk) disable iff (rst)
        divStart |-> (!busy && divisor != '0))
        else $error("serialDivider: start while busy or with zero divisor");

endmodule

//--- verilog/metricsEngine.sv
`timescale 1ns/1ps

module metricsEngine import fitnessPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fifoValid,
    input  activityT                fifoActivity,
    input  logic [DataWidth-1:0]    fifoSeconds,
    input  logic [DataWidth-1:0]    weight,
    input  logic [DataWidth-1:0]    restingRate,
    input  logic [DataWidth-1:0]    distance,
    output logic                    fifoReady,
    output logic [DataWidth-1:0]    secondsRun,
    output logic [DataWidth-1:0]    secondsWalk,
    output logic [DataWidth-1:0]    secondsCycle,
    output logic [CalorieWidth-1:0] caloriesRun,
    output logic [CalorieWidth-1:0] caloriesWalk,
    output logic [CalorieWidth-1:0] caloriesCycle,
    output logic [DataWidth-1:0]    speed,
    output logic [DataWidth-1:0]    targetRate,
    output logic                    resultValid
);

    engineStateT             state;
    activityT                curAct;
    logic [DataWidth-1:0]    curSec;
    logic [DataWidth-1:0]    storeRun;
    logic [DataWidth-1:0]    storeWalk;
    logic [DataWidth-1:0]    storeCycle;
    logic [DataWidth-1:0]    nextRun;
    logic [DataWidth-1:0]    nextWalk;
    logic [DataWidth-1:0]    nextCycle;
    logic [DataWidth-1:0]    timeSum;
    logic [DataWidth-1:0]    timeTotal;
    logic [CalorieWidth-1:0] rateSel;
    logic [CalorieWidth-1:0] calNew;
    logic [DataWidth-1:0]    speedNew;
    logic                    divStart;
    logic                    divDone;
    logic [DataWidth-1:0]    quotient;

    assign fifoReady = (state == idle);

    // Latest count replaces the stored one for its activity
    assign nextRun   = (curAct == actRun)   ? curSec : storeRun;
    assign nextWalk  = (curAct == actWalk)  ? curSec : storeWalk;
    assign nextCycle = (curAct == actCycle) ? curSec : storeCycle;
    assign timeSum   = nextRun + nextWalk + nextCycle;    // At most 3 x 59, no carry out

    always_comb begin
        case (curAct)
            actRun:   rateSel = CalorieWidth'(RateRun);
            actWalk:  rateSel = CalorieWidth'(RateWalk);
            actCycle: rateSel = CalorieWidth'(RateCycle);
            default:  rateSel = '0;
        endcase
    end

    assign divStart = (state == calc) && (timeSum != '0);
    assign speedNew = (timeTotal == '0) ? '0 : quotient;

    serialDivider serialDivider_i (
        .clk      (clk),
        .rst      (rst),
        .divStart (divStart),
        .dividend (distance),
        .divisor  (timeSum),
        .divDone  (divDone),
        .quotient (quotient)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= idle;
            curAct     <= actIdle;
            curSec     <= '0;
            storeRun   <= '0;
            storeWalk  <= '0;
            storeCycle <= '0;
            timeTotal  <= '0;
            calNew     <= '0;
        end else begin
            case (state)
                idle: begin
                    if (fifoValid) begin
                        curAct <= fifoActivity;
                        curSec <= fifoSeconds;
                        state  <= calc;
                    end
                end
                calc: begin
                    storeRun   <= nextRun;
                    storeWalk  <= nextWalk;
                    storeCycle <= nextCycle;
                    timeTotal  <= timeSum;
                    calNew     <= CalorieWidth'(weight) * rateSel * CalorieWidth'(curSec);
                    state      <= (timeSum == '0) ? publish : divide;    // No time, no divide
                end
                divide: begin
                    if (divDone) begin
                        state <= publish;
                    end
                end
                publish: state <= idle;
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            secondsRun    <= '0;
            secondsWalk   <= '0;
            secondsCycle  <= '0;
            caloriesRun   <= '0;
            caloriesWalk  <= '0;
            caloriesCycle <= '0;
            speed         <= '0;
            targetRate    <= '0;
            resultValid   <= 1'b0;
        end else begin
            resultValid <= (state == publish);
            if (state == publish) begin
                secondsRun   <= storeRun;
                secondsWalk  <= storeWalk;
                secondsCycle <= storeCycle;
                case (curAct)
                    actRun:   caloriesRun   <= calNew;
                    actWalk:  caloriesWalk  <= calNew;
                    actCycle: caloriesCycle <= calNew;
                    default:  ;
                endcase
                speed      <= speedNew;
                targetRate <= restingRate + weight / DataWidth'(2)
                              + speedNew / DataWidth'(3);    // Wraps at 8 bits
            end
        end
    end

    // Divider completion only makes sense while the FSM waits for it
    doneInDivide: assert property (@(posedge clk) disable iff (rst)
        divDone |-> (state == divide))
        else $error("metricsEngine: divDone outside divide state");

endmodule

//--- verilog/fitnessTracker.sv
`timescale 1ns/1ps

module fitnessTracker import fitnessPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    secTick,
    input  activityT                activity,
    input  logic [DataWidth-1:0]    weight,
    input  logic [DataWidth-1:0]    restingRate,
    input  logic [DataWidth-1:0]    distance,
    output logic [DataWidth-1:0]    secondsRun,
    output logic [DataWidth-1:0]    secondsWalk,
    output logic [DataWidth-1:0]    secondsCycle,
    output logic [CalorieWidth-1:0] caloriesRun,
    output logic [CalorieWidth-1:0] caloriesWalk,
    output logic [CalorieWidth-1:0] caloriesCycle,
    output logic [DataWidth-1:0]    speed,
    output logic [DataWidth-1:0]    targetRate,
    output logic                    resultValid
);

    logic                 sampleValid;      // Timer to FIFO
    logic                 sampleReady;
    activityT             sampleActivity;
    logic [DataWidth-1:0] sampleSeconds;
    logic                 fifoValid;        // FIFO to engine
    logic                 fifoReady;
    activityT             fifoActivity;
    logic [DataWidth-1:0] fifoSeconds;

    activityTimer activityTimer_i (
        .clk            (clk),
        .rst            (rst),
        .secTick        (secTick),
        .activity       (activity),
        .sampleReady    (sampleReady),
        .sampleValid    (sampleValid),
        .sampleActivity (sampleActivity),
        .sampleSeconds  (sampleSeconds)
    );

    sampleFifo sampleFifo_i (
        .clk            (clk),
        .rst            (rst),
        .sampleValid    (sampleValid),
        .sampleActivity (sampleActivity),
        .sampleSeconds  (sampleSeconds),
        .sampleReady    (sampleReady),
        .fifoValid      (fifoValid),
        .fifoActivity   (fifoActivity),
        .fifoSeconds    (fifoSeconds),
        .fifoReady      (fifoReady)
    );

    metricsEngine metricsEngine_i (
        .clk           (clk),
        .rst           (rst),
        .fifoValid     (fifoValid),
        .fifoActivity  (fifoActivity),
        .fifoSeconds   (fifoSeconds),
        .weight        (weight),
        .restingRate   (restingRate),
        .distance      (distance),
        .fifoReady     (fifoReady),
        .secondsRun    (secondsRun),
        .secondsWalk   (secondsWalk),
        .secondsCycle  (secondsCycle),
        .caloriesRun   (caloriesRun),
        .caloriesWalk  (caloriesWalk),
        .caloriesCycle (caloriesCycle),
        .speed         (speed),
        .targetRate    (targetRate),
        .resultValid   (resultValid)
    );

endmodule

//--- test/resultChecker.sv
`timescale 1ns/1ps

module resultChecker import fitnessPkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    resultValid,
    input  logic [DataWidth-1:0]    secondsRun,
    input  logic [DataWidth-1:0]    secondsWalk,
    input  logic [DataWidth-1:0]    secondsCycle,
    input  logic [CalorieWidth-1:0] caloriesRun,
    input  logic [CalorieWidth-1:0] caloriesWalk,
    input  logic [CalorieWidth-1:0] caloriesCycle,
    input  logic [DataWidth-1:0]    speed,
    input  logic [DataWidth-1:0]    targetRate,
    output int                      resultCount,
    output int                      errorCount
);

    localparam int Cols     = 14;
    localparam int MaxLines = 48;

    logic [CalorieWidth-1:0] vec [Cols*MaxLines];
    int                      lineCount;
    int                      lineIdx;
    int                      repsLeft;
    logic                    resetChecked;

    // Idle lines expect no result
    function automatic int nextActive(input int from);
        int i;
        i = from;
        while (i < lineCount && vec[i*Cols+3] == '0) begin
            i++;
        end
        return i;
    endfunction

    task automatic compare(input string name, input logic [CalorieWidth-1:0] got,
                           input logic [CalorieWidth-1:0] exp);
        if (got != exp) begin
            $display("[FAIL] %0d ns %s: got %0h, expected %0h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    task automatic compareOutputs(input int base, input logic expectZero);
        logic [CalorieWidth-1:0] exp [8];
        int                      k;
        for (k = 0; k < 8; k++) begin
            exp[k] = expectZero ? '0 : vec[base+6+k];    // Expected columns start at 6
        end
        compare("secondsRun", CalorieWidth'(secondsRun), exp[0]);
        compare("secondsWalk", CalorieWidth'(secondsWalk), exp[1]);
        compare("secondsCycle", CalorieWidth'(secondsCycle), exp[2]);
        compare("caloriesRun", caloriesRun, exp[3]);
        compare("caloriesWalk", caloriesWalk, exp[4]);
        compare("caloriesCycle", caloriesCycle, exp[5]);
        compare("speed", CalorieWidth'(speed), exp[6]);
        compare("targetRate", CalorieWidth'(targetRate), exp[7]);
    endtask

    initial begin
        int i;
        resultCount  = 0;
        errorCount   = 0;
        resetChecked = 1'b0;
        for (i = 0; i < Cols*MaxLines; i++) begin
            vec[i] = 24'hf00000 | CalorieWidth'(i);    // Top nibble f marks an unused line
        end
        $readmemh("test/testdata.txt", vec);
        lineCount = 0;
        while (lineCount < MaxLines && vec[lineCount*Cols][CalorieWidth-1 -: 4] != 4'hf) begin
            lineCount++;
        end
        lineIdx  = nextActive(0);
        repsLeft = (lineIdx < lineCount) ? int'(vec[lineIdx*Cols+5]) : 0;
    end

    always @(negedge clk) begin
        if (!rst && !resetChecked) begin
            compare("resultValid", CalorieWidth'(resultValid), '0);    // Quiet after reset
            compareOutputs(0, 1'b1);
            resetChecked = 1'b1;
        end else if (!rst && resultValid) begin
            resultCount++;
            if (lineIdx >= lineCount) begin
                $display("Result %0d at %0d ns has no tick left to match it", resultCount, $time);
                errorCount++;
            end else begin
                repsLeft--;
                if (repsLeft == 0) begin                  // Only the last tick of a line is checked
                    compareOutputs(lineIdx * Cols, 1'b0);
                    lineIdx = nextActive(lineIdx + 1);
                    if (lineIdx < lineCount) begin
                        repsLeft = int'(vec[lineIdx*Cols+5]);
                    end
                end
            end
        end
    end

endmodule

//--- test/fitnessTrackerTb.sv
`timescale 1ns/1ps

module fitnessTrackerTb
    import fitnessPkg::*;
();

    localparam int Cols       = 14;     // Six stimulus and eight expected columns
    localparam int MaxLines   = 48;
    localparam int DrainLimit = 200;    // Cycles allowed for the pipeline to empty

    logic                    clk;
    logic                    rst;
    logic                    secTick;
    activityT                activity;
    logic [DataWidth-1:0]    weight;
    logic [DataWidth-1:0]    restingRate;
    logic [DataWidth-1:0]    distance;
    logic [DataWidth-1:0]    secondsRun;
    logic [DataWidth-1:0]    secondsWalk;
    logic [DataWidth-1:0]    secondsCycle;
    logic [CalorieWidth-1:0] caloriesRun;
    logic [CalorieWidth-1:0] caloriesWalk;
    logic [CalorieWidth-1:0] caloriesCycle;
    logic [DataWidth-1:0]    speed;
    logic [DataWidth-1:0]    targetRate;
    logic                    resultValid;
    int                      resultCount;
    int                      errorCount;
    int                      issued;            // Active ticks sent so far
    int                      otherErrors;
    logic [CalorieWidth-1:0] vec [Cols*MaxLines];

    fitnessTracker fitnessTracker_i (
        .clk           (clk),
        .rst           (rst),
        .secTick       (secTick),
        .activity      (activity),
        .weight        (weight),
        .restingRate   (restingRate),
        .distance      (distance),
        .secondsRun    (secondsRun),
        .secondsWalk   (secondsWalk),
        .secondsCycle  (secondsCycle),
        .caloriesRun   (caloriesRun),
        .caloriesWalk  (caloriesWalk),
        .caloriesCycle (caloriesCycle),
        .speed         (speed),
        .targetRate    (targetRate),
        .resultValid   (resultValid)
    );

    resultChecker resultChecker_i (
        .clk           (clk),
        .rst           (rst),
        .resultValid   (resultValid),
        .secondsRun    (secondsRun),
        .secondsWalk   (secondsWalk),
        .secondsCycle  (secondsCycle),
        .caloriesRun   (caloriesRun),
        .caloriesWalk  (caloriesWalk),
        .caloriesCycle (caloriesCycle),
        .speed         (speed),
        .targetRate    (targetRate),
        .resultCount   (resultCount),
        .errorCount    (errorCount)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // One-cycle strobe, then idle until the next tick is due
    task automatic sendTick(input int gapCycles);
        secTick = 1'b1;
        @(negedge clk);
        secTick = 1'b0;
        repeat (gapCycles - 1) @(negedge clk);
    endtask

    task automatic waitDrain(output logic timedOut);
        int cycles;
        cycles   = 0;
        timedOut = 1'b0;
        while (resultCount < issued && cycles < DrainLimit) begin
            @(posedge clk);                    // Checker counts on the falling edge
            cycles++;
        end
        if (resultCount < issued) begin
            $display("Timed out after %0d cycles, only %0d of %0d results arrived",
                     DrainLimit, resultCount, issued);
            timedOut = 1'b1;
        end
        @(negedge clk);
    endtask

    initial begin
        int   line;
        int   rep;
        int   base;
        int   i;
        logic timedOut;
        rst         = 1'b1;
        secTick     = 1'b0;
        activity    = actIdle;
        weight      = '0;
        restingRate = '0;
        distance    = '0;
        issued      = 0;
        otherErrors = 0;
        timedOut    = 1'b0;
        for (i = 0; i < Cols*MaxLines; i++) begin
            vec[i] = 24'hf00000 | CalorieWidth'(i);    // Top nibble f marks an unused line
        end
        $readmemh("test/testdata.txt", vec);
        repeat (2) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        line = 0;
        while (!timedOut && line < MaxLines && vec[line*Cols][CalorieWidth-1 -: 4] != 4'hf) begin
            base = line * Cols;
            if (weight != vec[base][DataWidth-1:0] || restingRate != vec[base+1][DataWidth-1:0]
                || distance != vec[base+2][DataWidth-1:0]) begin
                waitDrain(timedOut);           // Profile may only change on an empty pipeline
            end
            weight      = vec[base][DataWidth-1:0];
            restingRate = vec[base+1][DataWidth-1:0];
            distance    = vec[base+2][DataWidth-1:0];
            activity    = activityT'(vec[base+3][1:0]);
            for (rep = 0; rep < int'(vec[base+5]) && !timedOut; rep++) begin
                sendTick(int'(vec[base+4]));
                if (activity != actIdle) begin
                    issued++;
                end
            end
            line++;
        end
        if (!timedOut) begin
            waitDrain(timedOut);
        end
        if (timedOut) begin
            otherErrors++;
        end
        if (resultCount > issued) begin
            $display("Got %0d results for %0d active ticks, extra results came out",
                     resultCount, issued);
            otherErrors++;
        end
        $display("Results %0d of %0d, value mismatches %0d, other errors %0d",
                 resultCount, issued, errorCount, otherErrors);
        if (errorCount == 0 && otherErrors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- build.f
verilog/fitnessPkg.sv
verilog/activityTimer.sv
verilog/sampleFifo.sv
verilog/serialDivider.sv
verilog/metricsEngine.sv
verilog/fitnessTracker.sv
test/resultChecker.sv
test/fitnessTrackerTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= fitnessTrackerTb
FILELIST  ?= build.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --assert --timing -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIMBIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIMBIN)

# Rebuilt only when a source or the file list changes
$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

# The run passes only when the pass line appears in the output
run: $(SIMBIN)
	@out="$$($(SIMBIN))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJDIR)

//--- test/testdata.txt
// Hex columns: weight restingRate distance activity gap reps | expected secondsRun secondsWalk
// secondsCycle caloriesRun caloriesWalk caloriesCycle speed targetRate (after the line's last tick)
40 3c 64 1 f 1   1 0 0  280 0 0  64 7d
40 3c 64 1 f 1   2 0 0  500 0 0  32 6c
40 3c 64 1 f 39  3b 0 0  9380 0 0  1 5c
// Run count wraps to 0 with no other time, speed falls back to 0
40 3c 64 1 f 1   0 0 0  0 0 0  0 5c
40 3c 64 0 f 1   0 0 0  0 0 0  0 0
50 46 c8 2 f 3   0 3 0  0 4b0 0  42 84
50 46 c8 3 f 4   0 3 4  0 4b0 a00  1c 77
50 46 c8 0 f 2   0 0 0  0 0 0  0 0
50 46 c8 1 f 1   1 3 4  320 4b0 a00  19 76
// Heavy profiles, target rate wraps at 8 bits
f0 c8 ff 2 f 1   1 4 4  320 12c0 a00  1c 49
f0 c8 ff 3 f 32  1 4 36  320 12c0 19500  4 41
ff ff ff 1 f 1   2 4 36  13ec 12c0 19500  4 7f
// Burst of four ticks two cycles apart
ff ff ff 1 2 1   3 4 36  1de2 12c0 19500  4 7f
ff ff ff 2 2 1   3 5 36  1de2 18e7 19500  4 7f
ff ff ff 3 2 1   3 5 37  1de2 18e7 1b648  4 7f
ff ff ff 1 f 1   4 5 37  27d8 18e7 1b648  3 7f
